// ==== design/ea_pkg.sv ====
package ea_pkg;

    // Address and 16-bit register width.
    localparam int ADDR_W = 16;

    // Wishbone data bus width.
    localparam int DATA_W = 8;

    // Decoded indexed addressing mode.
    typedef enum logic [3:0] {
        // Bit 7 set, 5-bit signed offset.
        MODE_OFF5  = 4'd0,
        // Constant offsets.
        MODE_INC1  = 4'd1,
        MODE_INC2  = 4'd2,
        MODE_DEC1  = 4'd3,
        MODE_DEC2  = 4'd4,
        MODE_ZERO  = 4'd5,
        // Accumulator offsets.
        MODE_ACC_B = 4'd6,
        MODE_ACC_A = 4'd7,
        MODE_ACC_D = 4'd8,
        // Offsets fetched as operand bytes.
        MODE_OFF8  = 4'd9,
        MODE_OFF16 = 4'd10,
        // Operand offsets added to the PC after the operands.
        MODE_PCR8  = 4'd11,
        MODE_PCR16 = 4'd12,
        // Operand is the address itself.
        MODE_EXT   = 4'd13,
        // Unused low-nibble codes, zero offset.
        MODE_RSVD  = 4'd14
    } idx_mode_e;

    // Fetch sequencer states.
    typedef enum logic [2:0] {
        S_IDLE    = 3'd0,
        S_POST    = 3'd1,
        S_OPND_HI = 3'd2,
        S_OPND_LO = 3'd3,
        S_CALC    = 3'd4,
        S_IND_HI  = 3'd5,
        S_IND_LO  = 3'd6,
        S_DONE    = 3'd7
    } seq_state_e;

endpackage

// ==== design/idx_calc.sv ====
`timescale 1ns/10ps

module idx_calc (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [ea_pkg::DATA_W-1:0] postbyte,
    input  logic [ea_pkg::ADDR_W-1:0] operand,
    input  logic [ea_pkg::ADDR_W-1:0] pc_after,
    input  logic                      calc,
    input  logic [ea_pkg::ADDR_W-1:0] x,
    input  logic [ea_pkg::ADDR_W-1:0] y,
    input  logic [ea_pkg::ADDR_W-1:0] u,
    input  logic [ea_pkg::ADDR_W-1:0] s,
    input  logic [ea_pkg::DATA_W-1:0] a,
    input  logic [ea_pkg::DATA_W-1:0] b,
    output ea_pkg::idx_mode_e         mode,
    output logic                      indirect,
    output logic [ea_pkg::ADDR_W-1:0] addr
);

    import ea_pkg::*;

    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] offset;

    // Postbyte decode.
    always_comb begin
        if (postbyte[7]) begin
            mode = MODE_OFF5;
        end else begin
            case (postbyte[3:0])
                4'b0000: mode = MODE_INC1;
                4'b0001: mode = MODE_INC2;
                4'b0010: mode = MODE_DEC1;
                4'b0011: mode = MODE_DEC2;
                4'b0100: mode = MODE_ZERO;
                4'b0101: mode = MODE_ACC_B;
                4'b0110: mode = MODE_ACC_A;
                4'b1000: mode = MODE_OFF8;
                4'b1001: mode = MODE_OFF16;
                4'b1011: mode = MODE_ACC_D;
                4'b1100: mode = MODE_PCR8;
                4'b1101: mode = MODE_PCR16;
                4'b1111: mode = MODE_EXT;
                default: mode = MODE_RSVD;
            endcase
        end
    end

    // Bit 4 is part of the offset in the short form.
    assign indirect = ~postbyte[7] & postbyte[4];

    // Base register select.
    always_comb begin
        case (postbyte[6:5])
            2'b00:   base = x;
            2'b01:   base = y;
            2'b10:   base = u;
            default: base = s;
        endcase
        // PC-relative uses the PC past the operands.
        if (mode == MODE_PCR8 || mode == MODE_PCR16) begin
            base = pc_after;
        end
    end

    // Offset table.
    always_comb begin
        case (mode)
            MODE_OFF5:  offset = {{(ADDR_W-5){postbyte[4]}}, postbyte[4:0]};
            MODE_INC1:  offset = ADDR_W'(1);
            MODE_INC2:  offset = ADDR_W'(2);
            MODE_DEC1:  offset = {ADDR_W{1'b1}};
            MODE_DEC2:  offset = {{(ADDR_W-1){1'b1}}, 1'b0};
            MODE_ACC_B: offset = {{(ADDR_W-DATA_W){b[DATA_W-1]}}, b};
            MODE_ACC_A: offset = {{(ADDR_W-DATA_W){a[DATA_W-1]}}, a};
            MODE_ACC_D: offset = {a, b};
            // Single bytes arrive already sign-extended.
            MODE_OFF8,
            MODE_OFF16,
            MODE_PCR8,
            MODE_PCR16: offset = operand;
            default:    offset = '0;
        endcase
    end

    // Address register, loaded once per request.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
        end else if (calc) begin
            // Extended takes the operand as is.
            addr <= (mode == MODE_EXT) ? operand : base + offset;
        end
    end

endmodule

// ==== design/ea_fetch_seq.sv ====
`timescale 1ns/10ps

module ea_fetch_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ea_pkg::ADDR_W-1:0] pc,
    input  logic [ea_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                      wb_ack,
    input  ea_pkg::idx_mode_e         mode,
    input  logic                      indirect,
    input  logic [ea_pkg::ADDR_W-1:0] addr,
    output logic                      busy,
    output logic                      done,
    output logic [ea_pkg::ADDR_W-1:0] ea,
    output logic [ea_pkg::ADDR_W-1:0] next_pc,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [ea_pkg::ADDR_W-1:0] wb_adr,
    output logic [ea_pkg::DATA_W-1:0] postbyte,
    output logic [ea_pkg::ADDR_W-1:0] operand,
    output logic [ea_pkg::ADDR_W-1:0] pc_after,
    output logic                      calc
);

    import ea_pkg::*;

    seq_state_e        state;
    logic              cyc_q;
    logic              one_byte;
    logic              take;
    logic [1:0]        opnd_cnt;
    logic [DATA_W-1:0] post_q;

    // A byte is accepted on an acked edge of an open cycle.
    assign take = cyc_q & wb_ack;

    // Read-only master.
    assign wb_cyc = cyc_q;
    assign wb_stb = cyc_q;
    assign wb_we  = 1'b0;

    // Postbyte straight off the bus while it is being fetched,
    // so the operand count is known on the ack edge.
    assign postbyte = (state == S_POST) ? wb_dat_i : post_q;

    assign calc = (state == S_CALC);

    // Operand bytes that follow the postbyte.
    always_comb begin
        case (mode)
            MODE_OFF8,
            MODE_PCR8:  opnd_cnt = 2'd1;
            MODE_OFF16,
            MODE_PCR16,
            MODE_EXT:   opnd_cnt = 2'd2;
            default:    opnd_cnt = 2'd0;
        endcase
    end

    // Bus address.
    always_comb begin
        case (state)
            // Indirect pointer, big-endian.
            S_IND_HI: wb_adr = addr;
            S_IND_LO: wb_adr = addr + ADDR_W'(1);
            // pc_after runs one ahead of the byte in flight.
            default:  wb_adr = pc_after - ADDR_W'(1);
        endcase
    end

    // Control FSM.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            cyc_q    <= 1'b0;
            one_byte <= 1'b0;
            pc_after <= '0;
            ea       <= '0;
            next_pc  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        // Open the postbyte read at pc.
                        busy     <= 1'b1;
                        cyc_q    <= 1'b1;
                        pc_after <= pc + ADDR_W'(1);
                        state    <= S_POST;
                    end
                end
                S_POST: begin
                    if (take) begin
                        case (opnd_cnt)
                            2'd0: begin
                                cyc_q <= 1'b0;
                                state <= S_CALC;
                            end
                            2'd1: begin
                                // Single byte goes to the low half.
                                one_byte <= 1'b1;
                                pc_after <= pc_after + ADDR_W'(1);
                                state    <= S_OPND_LO;
                            end
                            default: begin
                                one_byte <= 1'b0;
                                pc_after <= pc_after + ADDR_W'(1);
                                state    <= S_OPND_HI;
                            end
                        endcase
                    end
                end
                S_OPND_HI: begin
                    if (take) begin
                        pc_after <= pc_after + ADDR_W'(1);
                        state    <= S_OPND_LO;
                    end
                end
                S_OPND_LO: begin
                    if (take) begin
                        cyc_q <= 1'b0;
                        state <= S_CALC;
                    end
                end
                S_CALC: begin
                    // addr is valid from the next cycle.
                    if (indirect) begin
                        cyc_q <= 1'b1;
                        state <= S_IND_HI;
                    end else begin
                        state <= S_DONE;
                    end
                end
                S_IND_HI: begin
                    if (take) begin
                        ea[ADDR_W-1:DATA_W] <= wb_dat_i;
                        state               <= S_IND_LO;
                    end
                end
                S_IND_LO: begin
                    if (take) begin
                        ea[DATA_W-1:0] <= wb_dat_i;
                        cyc_q          <= 1'b0;
                        state          <= S_DONE;
                    end
                end
                S_DONE: begin
                    // Pointer already sits in ea when indirect.
                    if (!indirect) begin
                        ea <= addr;
                    end
                    next_pc <= pc_after;
                    done    <= 1'b1;
                    busy    <= 1'b0;
                    state   <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Postbyte and operand capture.
    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                S_POST: begin
                    post_q <= wb_dat_i;
                end
                S_OPND_HI: begin
                    operand[ADDR_W-1:DATA_W] <= wb_dat_i;
                end
                S_OPND_LO: begin
                    if (one_byte) begin
                        operand <= {{(ADDR_W-DATA_W){wb_dat_i[DATA_W-1]}}, wb_dat_i};
                    end else begin
                        operand[DATA_W-1:0] <= wb_dat_i;
                    end
                end
                default: begin
                    post_q <= post_q;
                end
            endcase
        end
    end

endmodule

// ==== design/ea_unit_top.sv ====
`timescale 1ns/10ps

module ea_unit_top (
    input  logic                      clk,
    input  logic                      rst,
    // Request side.
    input  logic                      start,
    input  logic [ea_pkg::ADDR_W-1:0] pc,
    input  logic [ea_pkg::ADDR_W-1:0] x,
    input  logic [ea_pkg::ADDR_W-1:0] y,
    input  logic [ea_pkg::ADDR_W-1:0] u,
    input  logic [ea_pkg::ADDR_W-1:0] s,
    input  logic [ea_pkg::DATA_W-1:0] a,
    input  logic [ea_pkg::DATA_W-1:0] b,
    // Result side.
    output logic                      busy,
    output logic                      done,
    output logic [ea_pkg::ADDR_W-1:0] ea,
    output logic [ea_pkg::ADDR_W-1:0] next_pc,
    // Wishbone classic master.
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [ea_pkg::ADDR_W-1:0] wb_adr,
    input  logic [ea_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                      wb_ack
);

    import ea_pkg::*;

    // Sequencer to calculator.
    logic [DATA_W-1:0] postbyte;
    logic [ADDR_W-1:0] operand;
    logic [ADDR_W-1:0] pc_after;
    logic              calc;

    // Calculator back to sequencer.
    idx_mode_e         mode;
    logic              indirect;
    logic [ADDR_W-1:0] addr;

    // Bus owner and request FSM.
    ea_fetch_seq ea_fetch_seq_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .pc       (pc),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .mode     (mode),
        .indirect (indirect),
        .addr     (addr),
        .busy     (busy),
        .done     (done),
        .ea       (ea),
        .next_pc  (next_pc),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .postbyte (postbyte),
        .operand  (operand),
        .pc_after (pc_after),
        .calc     (calc)
    );

    // Postbyte decode and address add.
    idx_calc idx_calc_inst (
        .clk      (clk),
        .rst      (rst),
        .postbyte (postbyte),
        .operand  (operand),
        .pc_after (pc_after),
        .calc     (calc),
        .x        (x),
        .y        (y),
        .u        (u),
        .s        (s),
        .a        (a),
        .b        (b),
        .mode     (mode),
        .indirect (indirect),
        .addr     (addr)
    );

endmodule

// ==== test/wb_mem_slave.sv ====
`timescale 1ns/10ps

module wb_mem_slave (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [ea_pkg::ADDR_W-1:0] wb_adr,
    output logic [ea_pkg::DATA_W-1:0] wb_dat,
    output logic                      wb_ack,
    // Wait states before each ack.
    input  logic [1:0]                wait_states
);

    import ea_pkg::*;

    // Whole 64 KiB byte space, filled by the testbench.
    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
    logic [1:0]        wait_cnt;

    // Classic read, ack high for one cycle and then dropped.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_dat   <= '0;
            wait_cnt <= '0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt == wait_states) begin
                // Writes get an ack but are not stored.
                if (!wb_we) begin
                    wb_dat <= mem[wb_adr];
                end
                wb_ack   <= 1'b1;
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            wb_ack   <= 1'b0;
            wait_cnt <= '0;
        end
    end

endmodule

// ==== test/ea_tb.sv ====
`timescale 1ns/10ps

module ea_tb;

    import ea_pkg::*;

    // Cycles allowed for one request.
    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst;
    logic              start;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] x;
    logic [ADDR_W-1:0] y;
    logic [ADDR_W-1:0] u;
    logic [ADDR_W-1:0] s;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              busy;
    logic              done;
    logic [ADDR_W-1:0] ea;
    logic [ADDR_W-1:0] next_pc;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat;
    logic              wb_ack;
    logic [1:0]        wait_states;
    logic [31:0]       lcg_state;
    int                error_count;
    int                test_errors;
    int                test_count;
    int                test_failed;
    int                done_count;

    ea_unit_top ea_unit_top_inst (
        .clk(clk), .rst(rst), .start(start), .pc(pc),
        .x(x), .y(y), .u(u), .s(s), .a(a), .b(b),
        .busy(busy), .done(done), .ea(ea), .next_pc(next_pc),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat), .wb_ack(wb_ack)
    );

    wb_mem_slave wb_mem_slave_inst (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack), .wait_states(wait_states)
    );

    // 100 ns clock.
    always #50 clk = ~clk;

    // Count done pulses mid-cycle.
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    // LCG step returning the upper bits.
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [ADDR_W-1:0] sext8(input logic [DATA_W-1:0] v);
        return {{(ADDR_W-DATA_W){v[DATA_W-1]}}, v};
    endfunction

    // Big-endian word from slave memory.
    function automatic logic [ADDR_W-1:0] read_word(input logic [ADDR_W-1:0] ad);
        return {wb_mem_slave_inst.mem[ad], wb_mem_slave_inst.mem[ad + 16'd1]};
    endfunction

    // Reference model of the indexed postbyte rule.
    function automatic void model_ea(output idx_mode_e m, output logic [ADDR_W-1:0] ea_out,
                                     output logic [ADDR_W-1:0] pc_out);
        logic [DATA_W-1:0] pb;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] off;
        logic [ADDR_W-1:0] np;
        logic              ind;
        pb  = wb_mem_slave_inst.mem[pc];
        np  = pc + 16'd1;
        ind = 1'b0;
        off = '0;
        // Bits 6..5 pick the base in both forms.
        case (pb[6:5])
            2'b00:   base = x;
            2'b01:   base = y;
            2'b10:   base = u;
            default: base = s;
        endcase
        if (pb[7]) begin
            m   = MODE_OFF5;
            off = {{11{pb[4]}}, pb[4:0]};
        end else begin
            ind = pb[4];
            case (pb[3:0])
                4'h0: begin
                    m   = MODE_INC1;
                    off = 16'd1;
                end
                4'h1: begin
                    m   = MODE_INC2;
                    off = 16'd2;
                end
                4'h2: begin
                    m   = MODE_DEC1;
                    off = 16'hFFFF;
                end
                4'h3: begin
                    m   = MODE_DEC2;
                    off = 16'hFFFE;
                end
                4'h4: m = MODE_ZERO;
                4'h5: begin
                    m   = MODE_ACC_B;
                    off = sext8(b);
                end
                4'h6: begin
                    m   = MODE_ACC_A;
                    off = sext8(a);
                end
                4'hB: begin
                    m   = MODE_ACC_D;
                    off = {a, b};
                end
                4'h8: begin
                    m   = MODE_OFF8;
                    off = sext8(wb_mem_slave_inst.mem[np]);
                    np  = np + 16'd1;
                end
                4'h9: begin
                    m   = MODE_OFF16;
                    off = read_word(np);
                    np  = np + 16'd2;
                end
                // PC-relative base is the PC past the operands.
                4'hC: begin
                    m    = MODE_PCR8;
                    off  = sext8(wb_mem_slave_inst.mem[np]);
                    np   = np + 16'd1;
                    base = np;
                end
                4'hD: begin
                    m    = MODE_PCR16;
                    off  = read_word(np);
                    np   = np + 16'd2;
                    base = np;
                end
                // Extended mode takes the operand as the address.
                4'hF: begin
                    m    = MODE_EXT;
                    base = read_word(np);
                    np   = np + 16'd2;
                end
                default: m = MODE_RSVD;
            endcase
        end
        ea_out = ind ? read_word(base + off) : base + off;
        pc_out = np;
    endfunction

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] got);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic check_mode(input string name, input idx_mode_e exp, input idx_mode_e got);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected %s, got %s (%0d)", $time, name,
                     exp.name(), got.name(), got);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            error_count++;
        end
    endtask

    // One request with fresh registers, operands and wait states.
    task automatic run_case(input logic [DATA_W-1:0] pb, input logic poke);
        idx_mode_e         exp_mode;
        logic [ADDR_W-1:0] exp_ea;
        logic [ADDR_W-1:0] exp_pc;
        int                cycles;
        int                pulses;
        pc = lcg_next();
        x = lcg_next();
        y = lcg_next();
        u = lcg_next();
        s = lcg_next();
        a = DATA_W'(lcg_next());
        b = DATA_W'(lcg_next());
        wait_states = 2'(lcg_next());
        wb_mem_slave_inst.mem[pc] = pb;
        wb_mem_slave_inst.mem[pc + 16'd1] = DATA_W'(lcg_next());
        wb_mem_slave_inst.mem[pc + 16'd2] = DATA_W'(lcg_next());
        model_ea(exp_mode, exp_ea, exp_pc);
        pulses = done_count;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        // Postbyte read is open, read-only.
        check_bit("busy", 1'b1, busy);
        check_bit("wb_cyc", 1'b1, wb_cyc);
        check_bit("wb_stb", 1'b1, wb_stb);
        check_bit("wb_we", 1'b0, wb_we);
        // Second request at another pc is ignored while busy.
        if (poke) begin
            @(posedge clk);
            #1;
            pc = ~pc;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            pc = ~pc;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("Timeout, no done within %0d cycles for postbyte %h", TIMEOUT, pb);
            error_count++;
        end else begin
            check_addr("ea", exp_ea, ea);
            check_addr("next_pc", exp_pc, next_pc);
            check_mode("mode", exp_mode, ea_unit_top_inst.idx_calc_inst.mode);
            check_bit("busy", 1'b0, busy);
        end
        // Quiet window where a restart or extra pulse would show.
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        if (done_count != pulses + 1) begin
            $display("Expected one done pulse for postbyte %h, saw %0d", pb, done_count - pulses);
            error_count++;
        end
        check_bit("busy", 1'b0, busy);
        check_bit("wb_cyc", 1'b0, wb_cyc);
    endtask

    // Direct and indirect form of each nibble code in the list.
    task automatic sweep_codes(input logic [31:0] list, input int n);
        logic [15:0] rnd;
        for (int k = 0; k < n; k++) begin
            for (int ind = 0; ind < 2; ind++) begin
                rnd = lcg_next();
                run_case({1'b0, rnd[1:0], 1'(ind), list[k*4 +: 4]}, 1'b0);
            end
        end
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (error_count != test_errors) begin
            test_failed++;
            $display("Test %0d, %s: FAIL, %0d errors", test_count, name,
                     error_count - test_errors);
        end else begin
            $display("Test %0d, %s: ok", test_count, name);
        end
        test_errors = error_count;
    endtask

    initial begin
        logic [15:0] rnd;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        pc = '0;
        x = '0;
        y = '0;
        u = '0;
        s = '0;
        a = '0;
        b = '0;
        wait_states = '0;
        lcg_state = 32'd52;
        // Random contents over the whole 64 KiB.
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            wb_mem_slave_inst.mem[i] = DATA_W'(lcg_next());
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle outputs straight after reset.
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("wb_cyc", 1'b0, wb_cyc);
        check_bit("wb_stb", 1'b0, wb_stb);
        check_bit("wb_we", 1'b0, wb_we);
        check_addr("ea", '0, ea);
        check_addr("next_pc", '0, next_pc);
        rnd = lcg_next();
        run_case({1'b1, rnd[6:0]}, 1'b0);
        close_test("reset state and first request");
        // Each base register with both offset signs.
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                rnd = lcg_next();
                run_case({1'b1, 2'(r), k >= 2, rnd[3:0]}, 1'b0);
            end
        end
        close_test("5-bit offsets");
        sweep_codes(32'h0123456B, 8);
        close_test("constant and accumulator offsets");
        sweep_codes(32'h000089CD, 4);
        close_test("operand and PC-relative offsets");
        sweep_codes(32'h0000F7AE, 4);
        close_test("extended and reserved codes");
        for (int n = 0; n < 200; n++) begin
            rnd = lcg_next();
            run_case(rnd[7:0], rnd[12]);
        end
        close_test("random postbytes and wait states");
        $display("Tests: %0d, failed: %0d, errors: %0d", test_count, test_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/ea_pkg.sv
design/idx_calc.sv
design/ea_fetch_seq.sv
design/ea_unit_top.sv
test/wb_mem_slave.sv
test/ea_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal -f tb.f \
    --top-module ea_tb -o Vea_tb || exit 1
out=$(./obj_dir/Vea_tb)
echo "$out"
echo "$out" | grep -q 'All tests passed!' && exit 0 || exit 1
